// ==== flist.f ====
+incdir+design
design/soc_bus_pkg.sv
design/axi_lite_if.sv
design/ready_jitter.sv
design/axi_mem_slave.sv
design/axi_uart_slave.sv
design/axi_addr_decode.sv
design/soc_bus_top.sv
sim/soc_bus_assert.sv
sim/tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

export_include_dirs:
  - design

sources:
  - files:
      - design/soc_bus_pkg.sv
      - design/axi_lite_if.sv
      - design/ready_jitter.sv
      - design/axi_mem_slave.sv
      - design/axi_uart_slave.sv
      - design/axi_addr_decode.sv
      - design/soc_bus_top.sv
  - target: simulation
    files:
      - sim/soc_bus_assert.sv
      - sim/tb_soc_bus.sv

// ==== sim/tb_soc_bus.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module tb_soc_bus;

  localparam int unsigned N_WORDS     = 16;
  localparam int unsigned N_PART      = 24;
  localparam int unsigned N_UART      = 12;
  localparam int unsigned N_UNMAP     = 3;
  localparam int unsigned N_TXN       = 3 * N_WORDS + 2 * N_PART + N_UART + 1 + 2 * N_UNMAP;
  localparam int unsigned CYCLE_LIMIT = 40 * N_TXN;

  logic                   clk;
  logic                   rst_n_i;
  logic                   s_arvalid_i;
  logic                   s_arready_o;
  logic [`SOC_ID_W-1:0]   s_arid_i;
  logic [`SOC_ADDR_W-1:0] s_araddr_i;
  logic [7:0]             s_arlen_i;
  logic [2:0]             s_arsize_i;
  logic [1:0]             s_arburst_i;
  logic                   s_rvalid_o;
  logic                   s_rready_i;
  logic [`SOC_ID_W-1:0]   s_rid_o;
  logic [`SOC_DATA_W-1:0] s_rdata_o;
  logic [1:0]             s_rresp_o;
  logic                   s_rlast_o;
  logic                   s_awvalid_i;
  logic                   s_awready_o;
  logic [`SOC_ID_W-1:0]   s_awid_i;
  logic [`SOC_ADDR_W-1:0] s_awaddr_i;
  logic [7:0]             s_awlen_i;
  logic [2:0]             s_awsize_i;
  logic [1:0]             s_awburst_i;
  logic                   s_wvalid_i;
  logic                   s_wready_o;
  logic [`SOC_DATA_W-1:0] s_wdata_i;
  logic [`SOC_STRB_W-1:0] s_wstrb_i;
  logic                   s_wlast_i;
  logic                   s_bvalid_o;
  logic                   s_bready_i;
  logic [`SOC_ID_W-1:0]   s_bid_o;
  logic [1:0]             s_bresp_o;
  logic                   tx_valid_o;
  logic [7:0]             tx_data_o;

  logic [31:0]            lfsr_q = 32'h3336e226;
  logic [`SOC_DATA_W-1:0] model [1 << `SOC_MEM_WORDS_LOG2];
  logic [7:0]             tx_q [$];
  int unsigned            cycle_cnt = 0;

  soc_bus_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r[i] = lfsr_q[0];
    end
    return r;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_d, input logic [63:0] wdata,
                                              input logic [7:0] strb);
    logic [63:0] r;
    r = old_d;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_addr(input int unsigned idx);
    return `SOC_MEM_BASE + (idx << 3);
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      stop_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [3:0] id,
                          output logic [63:0] data, output logic [1:0] resp,
                          output logic [3:0] rid, output logic last);
    int unsigned hold;
    s_araddr_i  <= addr;
    s_arid_i    <= id;
    s_arvalid_i <= 1'b1;
    do @(posedge clk); while (!s_arready_o);
    s_arvalid_i <= 1'b0;
    do @(posedge clk); while (!s_rvalid_o);
    // back-pressure before taking the beat
    hold = rand_bits(3);
    repeat (hold) @(posedge clk);
    s_rready_i <= 1'b1;
    @(posedge clk);
    data = s_rdata_o;
    resp = s_rresp_o;
    rid  = s_rid_o;
    last = s_rlast_o;
    s_rready_i <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] id,
                           input logic [63:0] data, input logic [7:0] strb,
                           output logic [1:0] resp, output logic [3:0] bid);
    int unsigned hold;
    s_awaddr_i  <= addr;
    s_awid_i    <= id;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    do @(posedge clk); while (!(s_awready_o && s_wready_o));
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    do @(posedge clk); while (!s_bvalid_o);
    hold = rand_bits(3);
    repeat (hold) @(posedge clk);
    s_bready_i <= 1'b1;
    @(posedge clk);
    resp = s_bresp_o;
    bid  = s_bid_o;
    s_bready_i <= 1'b0;
  endtask

  task automatic write_mem_word(input int unsigned idx, input logic [63:0] data,
                                input logic [7:0] strb);
    logic [3:0] id;
    logic [3:0] bid;
    logic [1:0] resp;
    id = 4'(rand_bits(4));
    bus_write(mem_addr(idx), id, data, strb, resp, bid);
    check_eq("mem bresp", resp, soc_bus_pkg::OKAY);
    check_eq("mem bid", bid, id);
    model[idx] = merge_bytes(model[idx], data, strb);
  endtask

  task automatic check_mem_word(input int unsigned idx);
    logic [63:0] data;
    logic [3:0]  id;
    logic [3:0]  rid;
    logic [1:0]  resp;
    logic        last;
    id = 4'(rand_bits(4));
    bus_read(mem_addr(idx), id, data, resp, rid, last);
    check_eq($sformatf("mem rdata word %0d", idx), data, model[idx]);
    check_eq("mem rresp", resp, soc_bus_pkg::OKAY);
    check_eq("mem rid", rid, id);
    check_eq("mem rlast", last, 1'b1);
  endtask

  // uart byte strobes as seen on the pins
  always @(posedge clk) begin
    if (rst_n_i && tx_valid_o) begin
      tx_q.push_back(tx_data_o);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_run($sformatf("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT));
    end
    if (dut0.u_asrt.fail_cnt != 0) begin
      stop_run("a bus protocol assertion failed");
    end
  end

  initial begin
    logic [63:0] data;
    logic [7:0]  strb;
    logic [3:0]  id;
    logic [3:0]  rid;
    logic [1:0]  resp;
    logic        last;
    int unsigned k;
    int unsigned tx_expect;
    logic [31:0] bad_addr [N_UNMAP];

    rst_n_i     <= 1'b0;
    s_arvalid_i <= 1'b0;
    s_arid_i    <= '0;
    s_araddr_i  <= '0;
    s_arlen_i   <= 8'd0;
    s_arsize_i  <= 3'd3;
    s_arburst_i <= 2'b01;
    s_rready_i  <= 1'b0;
    s_awvalid_i <= 1'b0;
    s_awid_i    <= '0;
    s_awaddr_i  <= '0;
    s_awlen_i   <= 8'd0;
    s_awsize_i  <= 3'd3;
    s_awburst_i <= 2'b01;
    s_wvalid_i  <= 1'b0;
    s_wdata_i   <= '0;
    s_wstrb_i   <= '0;
    s_wlast_i   <= 1'b1;
    s_bready_i  <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    // idle cycles so the reset property sees quiet outputs
    repeat (2) @(posedge clk);

    // full-strobe writes each read back at once
    for (int i = 0; i < N_WORDS; i++) begin
      write_mem_word(i * 31, rand_bits(64), 8'hff);
      check_mem_word(i * 31);
    end

    // random strobes on the same words
    for (int i = 0; i < N_PART; i++) begin
      k    = 31 * rand_bits(4);
      data = rand_bits(64);
      strb = 8'(rand_bits(8));
      write_mem_word(k, data, strb);
      check_mem_word(k);
    end

    tx_expect = 0;
    for (int i = 0; i < N_UART; i++) begin
      data = rand_bits(64);
      strb = 8'(rand_bits(8));
      id   = 4'(rand_bits(4));
      bus_write(`SOC_UART_BASE, id, data, strb, resp, rid);
      check_eq("uart bresp", resp, soc_bus_pkg::OKAY);
      check_eq("uart bid", rid, id);
      if (strb[0]) begin
        tx_expect++;
      end
      check_eq("uart tx pulse count", tx_q.size(), tx_expect);
      if (strb[0]) begin
        check_eq("uart tx byte", tx_q[tx_q.size() - 1], data[7:0]);
      end
    end
    id = 4'(rand_bits(4));
    bus_read(`SOC_UART_BASE + 32'd4, id, data, resp, rid, last);
    check_eq("uart byte count", data, tx_expect);
    check_eq("uart rresp", resp, soc_bus_pkg::OKAY);
    check_eq("uart rid", rid, id);

    // far from both windows and just past each one
    bad_addr[0] = 32'h4000_0000;
    bad_addr[1] = `SOC_MEM_BASE + 32'h0000_1000;
    bad_addr[2] = `SOC_UART_BASE + 32'd8;
    for (int i = 0; i < N_UNMAP; i++) begin
      id = 4'(rand_bits(4));
      bus_write(bad_addr[i], id, rand_bits(64), 8'hff, resp, rid);
      check_eq("unmapped bresp", resp, soc_bus_pkg::DECERR);
      check_eq("unmapped bid", rid, id);
      id = 4'(rand_bits(4));
      bus_read(bad_addr[i], id, data, resp, rid, last);
      check_eq("unmapped rdata", data, 64'd0);
      check_eq("unmapped rresp", resp, soc_bus_pkg::DECERR);
      check_eq("unmapped rid", rid, id);
      check_eq("unmapped rlast", last, 1'b1);
    end
    check_eq("uart pulses after unmapped", tx_q.size(), tx_expect);

    for (int i = 0; i < N_WORDS; i++) begin
      check_mem_word(i * 31);
    end

    // drain the assertions on the final beats
    repeat (2) @(posedge clk);

    if (dut0.u_asrt.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_run("bus protocol assertions reported errors");
    end
  end

endmodule

`default_nettype wire

// ==== sim/soc_bus_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module soc_bus_assert (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   arready_i,
  input logic                   awvalid_i,
  input logic                   awready_i,
  input logic                   wvalid_i,
  input logic                   wready_i,
  input logic                   rvalid_i,
  input logic                   rready_i,
  input logic [`SOC_ID_W-1:0]   rid_i,
  input logic [`SOC_DATA_W-1:0] rdata_i,
  input logic [1:0]             rresp_i,
  input logic                   rlast_i,
  input logic                   bvalid_i,
  input logic                   bready_i,
  input logic [`SOC_ID_W-1:0]   bid_i,
  input logic [1:0]             bresp_i,
  input logic                   tx_valid_i
);

  int unsigned fail_cnt = 0;

  // one cycle after any reset edge
  reset_quiet: assert property (@(posedge clk) !rst_n_i |=>
    !arready_i && !awready_i && !wready_i && !rvalid_i && !bvalid_i && !tx_valid_i)
    else begin
      $error("control output high after reset");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rid_i) && $stable(rdata_i)
      && $stable(rresp_i) && $stable(rlast_i))
    else begin
      $error("read response changed before rready");
      fail_cnt++;
    end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i) && $stable(bresp_i))
    else begin
      $error("write response changed before bready");
      fail_cnt++;
    end

  // both readies together and only for a paired request
  aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n_i)
    (awready_i == wready_i) && (!awready_i || (awvalid_i && wvalid_i)))
    else begin
      $error("awready and wready differ or rose without both valids");
      fail_cnt++;
    end

  tx_single: assert property (@(posedge clk) disable iff (!rst_n_i) tx_valid_i |=> !tx_valid_i)
    else begin
      $error("tx_valid_o high two cycles in a row");
      fail_cnt++;
    end

endmodule

bind soc_bus_top soc_bus_assert u_asrt (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .arready_i  (s_arready_o),
  .awvalid_i  (s_awvalid_i),
  .awready_i  (s_awready_o),
  .wvalid_i   (s_wvalid_i),
  .wready_i   (s_wready_o),
  .rvalid_i   (s_rvalid_o),
  .rready_i   (s_rready_i),
  .rid_i      (s_rid_o),
  .rdata_i    (s_rdata_o),
  .rresp_i    (s_rresp_o),
  .rlast_i    (s_rlast_o),
  .bvalid_i   (s_bvalid_o),
  .bready_i   (s_bready_i),
  .bid_i      (s_bid_o),
  .bresp_i    (s_bresp_o),
  .tx_valid_i (tx_valid_o)
);

`default_nettype wire

// ==== design/soc_bus_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module soc_bus_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  input  logic [`SOC_ID_W-1:0]   s_arid_i,
  input  logic [`SOC_ADDR_W-1:0] s_araddr_i,
  input  logic [7:0]             s_arlen_i,
  input  logic [2:0]             s_arsize_i,
  input  logic [1:0]             s_arburst_i,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,
  output logic [`SOC_ID_W-1:0]   s_rid_o,
  output logic [`SOC_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rlast_o,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [`SOC_ID_W-1:0]   s_awid_i,
  input  logic [`SOC_ADDR_W-1:0] s_awaddr_i,
  input  logic [7:0]             s_awlen_i,
  input  logic [2:0]             s_awsize_i,
  input  logic [1:0]             s_awburst_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  input  logic [`SOC_DATA_W-1:0] s_wdata_i,
  input  logic [`SOC_STRB_W-1:0] s_wstrb_i,
  input  logic                   s_wlast_i,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  output logic [`SOC_ID_W-1:0]   s_bid_o,
  output logic [1:0]             s_bresp_o,
  output logic                   tx_valid_o,
  output logic [7:0]             tx_data_o
);

  axi_lite_if mem_bus ();
  axi_lite_if uart_bus ();

  // master port names match the decoder one to one
  axi_addr_decode u_decode (
    .mem_o  (mem_bus),
    .uart_o (uart_bus),
    .*
  );

  axi_mem_slave u_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus_i   (mem_bus)
  );

  axi_uart_slave u_uart (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .bus_i      (uart_bus),
    .tx_valid_o (tx_valid_o),
    .tx_data_o  (tx_data_o)
  );

endmodule

`default_nettype wire

// ==== design/axi_addr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module axi_addr_decode (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  input  logic [`SOC_ID_W-1:0]   s_arid_i,
  input  logic [`SOC_ADDR_W-1:0] s_araddr_i,
  input  logic [7:0]             s_arlen_i,
  input  logic [2:0]             s_arsize_i,
  input  logic [1:0]             s_arburst_i,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i,
  output logic [`SOC_ID_W-1:0]   s_rid_o,
  output logic [`SOC_DATA_W-1:0] s_rdata_o,
  output logic [1:0]             s_rresp_o,
  output logic                   s_rlast_o,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [`SOC_ID_W-1:0]   s_awid_i,
  input  logic [`SOC_ADDR_W-1:0] s_awaddr_i,
  input  logic [7:0]             s_awlen_i,
  input  logic [2:0]             s_awsize_i,
  input  logic [1:0]             s_awburst_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  input  logic [`SOC_DATA_W-1:0] s_wdata_i,
  input  logic [`SOC_STRB_W-1:0] s_wstrb_i,
  input  logic                   s_wlast_i,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  output logic [`SOC_ID_W-1:0]   s_bid_o,
  output logic [1:0]             s_bresp_o,
  axi_lite_if.mst                mem_o,
  axi_lite_if.mst                uart_o
);

  localparam logic [`SOC_ADDR_W-1:0] MEM_BASE  = `SOC_MEM_BASE;
  localparam logic [`SOC_ADDR_W-1:0] MEM_BYTES = 1 << (`SOC_MEM_WORDS_LOG2 + 3);
  localparam logic [`SOC_ADDR_W-1:0] UART_BASE = `SOC_UART_BASE;

  soc_bus_pkg::sel_e    rd_sel;
  soc_bus_pkg::sel_e    rd_sel_q;
  soc_bus_pkg::sel_e    wr_sel;
  soc_bus_pkg::sel_e    wr_sel_q;
  logic                 rd_busy_q;
  logic                 wr_busy_q;
  logic                 err_rvalid_q;
  logic                 err_bvalid_q;
  logic [`SOC_ID_W-1:0] err_rid_q;
  logic [`SOC_ID_W-1:0] err_bid_q;
  logic                 ar_hs;
  logic                 wr_hs;
  logic                 r_hs;
  logic                 b_hs;

  function automatic soc_bus_pkg::sel_e sel_of(input logic [`SOC_ADDR_W-1:0] addr);
    logic [`SOC_ADDR_W-1:0] mem_off;
    mem_off = addr - MEM_BASE;
    if (mem_off < MEM_BYTES) begin
      return soc_bus_pkg::SEL_MEM;
    end
    // 8 byte uart window
    if (addr[`SOC_ADDR_W-1:3] == UART_BASE[`SOC_ADDR_W-1:3]) begin
      return soc_bus_pkg::SEL_UART;
    end
    return soc_bus_pkg::SEL_NONE;
  endfunction

  // route on the live address only while idle
  assign rd_sel = rd_busy_q ? rd_sel_q : sel_of(s_araddr_i);
  assign wr_sel = wr_busy_q ? wr_sel_q : sel_of(s_awaddr_i);

  // request side toward the memory
  assign mem_o.arvalid = s_arvalid_i && !rd_busy_q && (rd_sel == soc_bus_pkg::SEL_MEM);
  assign mem_o.arid    = s_arid_i;
  assign mem_o.araddr  = s_araddr_i;
  assign mem_o.arlen   = s_arlen_i;
  assign mem_o.arsize  = s_arsize_i;
  assign mem_o.arburst = soc_bus_pkg::burst_e'(s_arburst_i);
  assign mem_o.rready  = s_rready_i && (rd_sel_q == soc_bus_pkg::SEL_MEM);
  assign mem_o.awvalid = s_awvalid_i && !wr_busy_q && (wr_sel == soc_bus_pkg::SEL_MEM);
  assign mem_o.awid    = s_awid_i;
  assign mem_o.awaddr  = s_awaddr_i;
  assign mem_o.awlen   = s_awlen_i;
  assign mem_o.awsize  = s_awsize_i;
  assign mem_o.awburst = soc_bus_pkg::burst_e'(s_awburst_i);
  assign mem_o.wvalid  = s_wvalid_i && !wr_busy_q && (wr_sel == soc_bus_pkg::SEL_MEM);
  assign mem_o.wdata   = s_wdata_i;
  assign mem_o.wstrb   = s_wstrb_i;
  assign mem_o.wlast   = s_wlast_i;
  assign mem_o.bready  = s_bready_i && (wr_sel_q == soc_bus_pkg::SEL_MEM);

  // request side toward the uart
  assign uart_o.arvalid = s_arvalid_i && !rd_busy_q && (rd_sel == soc_bus_pkg::SEL_UART);
  assign uart_o.arid    = s_arid_i;
  assign uart_o.araddr  = s_araddr_i;
  assign uart_o.arlen   = s_arlen_i;
  assign uart_o.arsize  = s_arsize_i;
  assign uart_o.arburst = soc_bus_pkg::burst_e'(s_arburst_i);
  assign uart_o.rready  = s_rready_i && (rd_sel_q == soc_bus_pkg::SEL_UART);
  assign uart_o.awvalid = s_awvalid_i && !wr_busy_q && (wr_sel == soc_bus_pkg::SEL_UART);
  assign uart_o.awid    = s_awid_i;
  assign uart_o.awaddr  = s_awaddr_i;
  assign uart_o.awlen   = s_awlen_i;
  assign uart_o.awsize  = s_awsize_i;
  assign uart_o.awburst = soc_bus_pkg::burst_e'(s_awburst_i);
  assign uart_o.wvalid  = s_wvalid_i && !wr_busy_q && (wr_sel == soc_bus_pkg::SEL_UART);
  assign uart_o.wdata   = s_wdata_i;
  assign uart_o.wstrb   = s_wstrb_i;
  assign uart_o.wlast   = s_wlast_i;
  assign uart_o.bready  = s_bready_i && (wr_sel_q == soc_bus_pkg::SEL_UART);

  // ready mux, unmapped requests are taken at once
  always_comb begin
    s_arready_o = 1'b0;
    s_awready_o = 1'b0;
    s_wready_o  = 1'b0;
    if (!rd_busy_q) begin
      case (rd_sel)
        soc_bus_pkg::SEL_MEM:  s_arready_o = mem_o.arready;
        soc_bus_pkg::SEL_UART: s_arready_o = uart_o.arready;
        default:               s_arready_o = s_arvalid_i;
      endcase
    end
    if (!wr_busy_q) begin
      case (wr_sel)
        soc_bus_pkg::SEL_MEM: begin
          s_awready_o = mem_o.awready;
          s_wready_o  = mem_o.wready;
        end
        soc_bus_pkg::SEL_UART: begin
          s_awready_o = uart_o.awready;
          s_wready_o  = uart_o.wready;
        end
        default: begin
          s_awready_o = s_awvalid_i && s_wvalid_i;
          s_wready_o  = s_awvalid_i && s_wvalid_i;
        end
      endcase
    end
  end

  // response mux on the latched selection
  always_comb begin
    case (rd_sel_q)
      soc_bus_pkg::SEL_MEM: begin
        s_rvalid_o = mem_o.rvalid;
        s_rid_o    = mem_o.rid;
        s_rdata_o  = mem_o.rdata;
        s_rresp_o  = mem_o.rresp;
        s_rlast_o  = mem_o.rlast;
      end
      soc_bus_pkg::SEL_UART: begin
        s_rvalid_o = uart_o.rvalid;
        s_rid_o    = uart_o.rid;
        s_rdata_o  = uart_o.rdata;
        s_rresp_o  = uart_o.rresp;
        s_rlast_o  = uart_o.rlast;
      end
      default: begin
        s_rvalid_o = err_rvalid_q;
        s_rid_o    = err_rid_q;
        s_rdata_o  = '0;
        s_rresp_o  = soc_bus_pkg::DECERR;
        s_rlast_o  = 1'b1;
      end
    endcase
    case (wr_sel_q)
      soc_bus_pkg::SEL_MEM: begin
        s_bvalid_o = mem_o.bvalid;
        s_bid_o    = mem_o.bid;
        s_bresp_o  = mem_o.bresp;
      end
      soc_bus_pkg::SEL_UART: begin
        s_bvalid_o = uart_o.bvalid;
        s_bid_o    = uart_o.bid;
        s_bresp_o  = uart_o.bresp;
      end
      default: begin
        s_bvalid_o = err_bvalid_q;
        s_bid_o    = err_bid_q;
        s_bresp_o  = soc_bus_pkg::DECERR;
      end
    endcase
  end

  assign ar_hs = s_arvalid_i && s_arready_o;
  assign wr_hs = s_awvalid_i && s_awready_o;
  assign r_hs  = s_rvalid_o && s_rready_i;
  assign b_hs  = s_bvalid_o && s_bready_i;

  // selection held from request to response
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_busy_q    <= 1'b0;
      wr_busy_q    <= 1'b0;
      rd_sel_q     <= soc_bus_pkg::SEL_NONE;
      wr_sel_q     <= soc_bus_pkg::SEL_NONE;
      err_rvalid_q <= 1'b0;
      err_bvalid_q <= 1'b0;
    end else begin
      if (ar_hs) begin
        rd_busy_q <= 1'b1;
        rd_sel_q  <= rd_sel;
      end else if (r_hs) begin
        rd_busy_q <= 1'b0;
      end
      if (wr_hs) begin
        wr_busy_q <= 1'b1;
        wr_sel_q  <= wr_sel;
      end else if (b_hs) begin
        wr_busy_q <= 1'b0;
      end
      if (ar_hs && rd_sel == soc_bus_pkg::SEL_NONE) begin
        err_rvalid_q <= 1'b1;
      end else if (s_rready_i) begin
        err_rvalid_q <= 1'b0;
      end
      if (wr_hs && wr_sel == soc_bus_pkg::SEL_NONE) begin
        err_bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        err_bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      err_rid_q <= s_arid_i;
    end
    if (wr_hs) begin
      err_bid_q <= s_awid_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_uart_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module axi_uart_slave (
  input  logic       clk,
  input  logic       rst_n_i,
  axi_lite_if.slv    bus_i,
  output logic       tx_valid_o,
  output logic [7:0] tx_data_o
);

  logic                 permit;
  logic                 ar_hs;
  logic                 wr_hs;
  logic                 rvalid_q;
  logic                 bvalid_q;
  logic                 tx_valid_q;
  logic [15:0]          byte_cnt_q;
  logic [15:0]          rdata_q;
  logic [`SOC_ID_W-1:0] rid_q;
  logic [`SOC_ID_W-1:0] bid_q;
  logic [7:0]           tx_data_q;

  ready_jitter u_jitter (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .permit_o (permit)
  );

  assign bus_i.arready = bus_i.arvalid && !rvalid_q && permit;
  assign ar_hs         = bus_i.arvalid && bus_i.arready;
  assign wr_hs         = bus_i.awvalid && bus_i.wvalid && !bvalid_q && permit;
  assign bus_i.awready = wr_hs;
  assign bus_i.wready  = wr_hs;

  // count snapshot taken at ar, zero extended
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rid    = rid_q;
  assign bus_i.rdata  = {{(`SOC_DATA_W-16){1'b0}}, rdata_q};
  assign bus_i.rresp  = soc_bus_pkg::OKAY;
  assign bus_i.rlast  = 1'b1;
  assign bus_i.bvalid = bvalid_q;
  assign bus_i.bid    = bid_q;
  assign bus_i.bresp  = soc_bus_pkg::OKAY;
  assign tx_valid_o   = tx_valid_q;
  assign tx_data_o    = tx_data_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rvalid_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      tx_valid_q <= 1'b0;
      byte_cnt_q <= '0;
    end else begin
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (bus_i.rready) begin
        rvalid_q <= 1'b0;
      end
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (bus_i.bready) begin
        bvalid_q <= 1'b0;
      end
      // single cycle strobe, bvalid blocks a second write next cycle
      tx_valid_q <= wr_hs && bus_i.wstrb[0];
      if (wr_hs && bus_i.wstrb[0]) begin
        byte_cnt_q <= byte_cnt_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rid_q   <= bus_i.arid;
      rdata_q <= byte_cnt_q;
    end
    if (wr_hs) begin
      bid_q     <= bus_i.awid;
      tx_data_q <= bus_i.wdata[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_mem_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module axi_mem_slave (
  input  logic    clk,
  input  logic    rst_n_i,
  axi_lite_if.slv bus_i
);

  localparam int unsigned DEPTH   = 1 << `SOC_MEM_WORDS_LOG2;
  localparam int unsigned IDX_LSB = 3;
  localparam int unsigned IDX_MSB = `SOC_MEM_WORDS_LOG2 + 2;

  logic [`SOC_DATA_W-1:0]         mem_q [DEPTH];
  soc_bus_pkg::mem_rd_state_e     rd_state_q;
  logic [`SOC_MEM_WORDS_LOG2-1:0] rd_idx_q;
  logic [`SOC_ID_W-1:0]           rid_q;
  logic [`SOC_DATA_W-1:0]         rdata_q;
  logic                           bvalid_q;
  logic [`SOC_ID_W-1:0]           bid_q;
  logic                           permit;
  logic                           ar_hs;
  logic                           wr_hs;
  logic [`SOC_MEM_WORDS_LOG2-1:0] wr_idx;

  ready_jitter u_jitter (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .permit_o (permit)
  );

  // read channel
  assign bus_i.arready = (rd_state_q == soc_bus_pkg::RD_IDLE) && bus_i.arvalid && permit;
  assign ar_hs         = bus_i.arvalid && bus_i.arready;
  assign bus_i.rvalid  = (rd_state_q == soc_bus_pkg::RD_RESP);
  assign bus_i.rid     = rid_q;
  assign bus_i.rdata   = rdata_q;
  assign bus_i.rresp   = soc_bus_pkg::OKAY;
  assign bus_i.rlast   = 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rd_state_q <= soc_bus_pkg::RD_IDLE;
    end else begin
      case (rd_state_q)
        soc_bus_pkg::RD_IDLE: begin
          if (ar_hs) begin
            rd_state_q <= soc_bus_pkg::RD_FETCH;
          end
        end
        soc_bus_pkg::RD_FETCH: begin
          rd_state_q <= soc_bus_pkg::RD_RESP;
        end
        soc_bus_pkg::RD_RESP: begin
          // hold the beat until the master takes it
          if (bus_i.rready) begin
            rd_state_q <= soc_bus_pkg::RD_IDLE;
          end
        end
        default: begin
          rd_state_q <= soc_bus_pkg::RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_idx_q <= bus_i.araddr[IDX_MSB:IDX_LSB];
      rid_q    <= bus_i.arid;
    end
    if (rd_state_q == soc_bus_pkg::RD_FETCH) begin
      rdata_q <= mem_q[rd_idx_q];
    end
  end

  // write channel, aw and w taken together
  assign wr_hs         = bus_i.awvalid && bus_i.wvalid && !bvalid_q && permit;
  assign bus_i.awready = wr_hs;
  assign bus_i.wready  = wr_hs;
  assign bus_i.bvalid  = bvalid_q;
  assign bus_i.bid     = bid_q;
  assign bus_i.bresp   = soc_bus_pkg::OKAY;
  assign wr_idx        = bus_i.awaddr[IDX_MSB:IDX_LSB];

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      // byte lane merge
      for (int b = 0; b < `SOC_STRB_W; b++) begin
        if (bus_i.wstrb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
      bid_q <= bus_i.awid;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_hs) begin
      bvalid_q <= 1'b1;
    end else if (bus_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/ready_jitter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

module ready_jitter (
  input  logic clk,
  input  logic rst_n_i,
  output logic permit_o
);

  logic [19:0] lfsr_q;

  // fibonacci form, taps 20 and 19
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      lfsr_q <= `SOC_JITTER_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  assign permit_o = (`SOC_STALL_EN != 0) ? lfsr_q[19] : 1'b1;

endmodule

`default_nettype wire

// ==== design/axi_lite_if.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_bus_macros.svh"

interface axi_lite_if;

  // read address and data
  logic                    arvalid;
  logic                    arready;
  logic [`SOC_ID_W-1:0]    arid;
  logic [`SOC_ADDR_W-1:0]  araddr;
  logic [7:0]              arlen;
  logic [2:0]              arsize;
  soc_bus_pkg::burst_e     arburst;
  logic                    rvalid;
  logic                    rready;
  logic [`SOC_ID_W-1:0]    rid;
  logic [`SOC_DATA_W-1:0]  rdata;
  soc_bus_pkg::resp_e      rresp;
  logic                    rlast;

  // write address, data and response
  logic                    awvalid;
  logic                    awready;
  logic [`SOC_ID_W-1:0]    awid;
  logic [`SOC_ADDR_W-1:0]  awaddr;
  logic [7:0]              awlen;
  logic [2:0]              awsize;
  soc_bus_pkg::burst_e     awburst;
  logic                    wvalid;
  logic                    wready;
  logic [`SOC_DATA_W-1:0]  wdata;
  logic [`SOC_STRB_W-1:0]  wstrb;
  logic                    wlast;
  logic                    bvalid;
  logic                    bready;
  logic [`SOC_ID_W-1:0]    bid;
  soc_bus_pkg::resp_e      bresp;

  modport mst (
    output arvalid, arid, araddr, arlen, arsize, arburst, rready,
    output awvalid, awid, awaddr, awlen, awsize, awburst,
    output wvalid, wdata, wstrb, wlast, bready,
    input  arready, rvalid, rid, rdata, rresp, rlast,
    input  awready, wready, bvalid, bid, bresp
  );

  modport slv (
    input  arvalid, arid, araddr, arlen, arsize, arburst, rready,
    input  awvalid, awid, awaddr, awlen, awsize, awburst,
    input  wvalid, wdata, wstrb, wlast, bready,
    output arready, rvalid, rid, rdata, rresp, rlast,
    output awready, wready, bvalid, bid, bresp
  );

endinterface

`default_nettype wire

// ==== design/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // carried on the bus, single beat only
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_RESP
  } mem_rd_state_e;

  // decoder target
  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_UART,
    SEL_NONE
  } sel_e;

endpackage

`default_nettype wire

// ==== design/soc_bus_macros.svh ====
`ifndef SOC_BUS_MACROS_SVH
`define SOC_BUS_MACROS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8
`define SOC_ID_W 4

// address map, memory is 512 words of 64 bits
`define SOC_MEM_BASE 32'h8000_0000
`define SOC_MEM_WORDS_LOG2 9
`define SOC_UART_BASE 32'ha000_03f8

// ready stalls from the lfsr, 0 keeps every slave always ready
`define SOC_STALL_EN 1
`define SOC_JITTER_SEED 20'h00065

`endif
